// ==== hw/conv_engine_top.sv ====
`timescale 1ns/1ps

module conv_engine_top
	import conv_pkg::*;
#(
	parameter int MEM_DEPTH = 1024,
	parameter int ADDR_W = $clog2(MEM_DEPTH)
)
(
	input  logic clk,
	input  logic rst,

	input  logic weight_we,
	input  logic [ADDR_W-1:0] weight_addr,
	input  logic [WORD_W-1:0] weight_data,

	input  logic feat_we,
	input  logic [$clog2(LANES)-1:0] feat_addr,
	input  logic [WORD_W-1:0] feat_data,

	input  logic step,
	input  layer_mode_t step_mode,
	input  logic [15:0] step_addr,
	input  logic acc_clear,

	output logic result_valid,
	output logic signed [ACC_W-1:0] result1,
	output logic signed [ACC_W-1:0] result2
);

	lane_bus bus();

	logic [LANES-1:0][ACC_W-1:0] prod1_all;
	logic [LANES-1:0][ACC_W-1:0] prod2_all;
	logic [LANES-1:0] lane_valid;
	logic [LANES-1:0] lane_clear;

	operand_dispatch #(
		.MEM_DEPTH(MEM_DEPTH),
		.ADDR_W(ADDR_W)
	) u_dispatch (
		.clk(clk),
		.rst(rst),
		.weight_we(weight_we),
		.weight_addr(weight_addr),
		.weight_data(weight_data),
		.feat_we(feat_we),
		.feat_addr(feat_addr),
		.feat_data(feat_data),
		.step(step),
		.step_mode(step_mode),
		.step_addr(step_addr),
		.acc_clear(acc_clear),
		.bus(bus)
	);

	//////////////////////////////
	// lanes
	//////////////////////////////

	genvar i;
	generate
		for (i = 0; i < LANES; i++)
		begin : g_lane
			mac_lane u_lane (
				.clk(clk),
				.rst(rst),
				.load(bus.feat_load[i]),
				.feat_in(bus.feat_data),
				.w1_in(bus.w1[i]),
				.w2_in(bus.w2[i]),
				.step_in(bus.step_valid),
				.clear_in(bus.step_clear),
				.prod1(prod1_all[i]),
				.prod2(prod2_all[i]),
				.prod_valid(lane_valid[i]),
				.prod_clear(lane_clear[i])
			);
		end
	endgenerate

	// all lanes share timing, lane 0 carries the tags
	psum_collector u_collector (
		.clk(clk),
		.rst(rst),
		.prod1_all(prod1_all),
		.prod2_all(prod2_all),
		.prod_valid(lane_valid[0]),
		.prod_clear(lane_clear[0]),
		.result_valid(result_valid),
		.result1(result1),
		.result2(result2)
	);

endmodule

// ==== hw/conv_pkg.sv ====
package conv_pkg;

	//////////////////////////////
	// word widths
	//////////////////////////////

	// weights and features
	localparam int WORD_W = 16;

	// products and accumulators
	localparam int ACC_W = 32;

	//////////////////////////////
	// array shape
	//////////////////////////////

	// multiply lanes, also the row length
	localparam int LANES = 8;

	// distance from the first bank to the second one in dual mode
	localparam int BANK_OFFSET = 200;

	//////////////////////////////
	// layer modes
	//////////////////////////////

	typedef enum logic [1:0]
	{
		MODE_IDLE = 2'd0,
		MODE_K3   = 2'd1,
		MODE_ROW8 = 2'd2,
		MODE_DUAL = 2'd3
	} layer_mode_t;

endpackage

// ==== hw/lane_bus.sv ====
`timescale 1ns/1ps

interface lane_bus
	import conv_pkg::*;
();

	// weight groups, element i goes to lane i
	logic [LANES-1:0][WORD_W-1:0] w1;
	logic [LANES-1:0][WORD_W-1:0] w2;

	// one-hot feature register select
	logic [LANES-1:0] feat_load;
	logic [WORD_W-1:0] feat_data;

	// step tags
	logic step_valid;
	logic step_clear;

	modport dispatch
	(
		output w1,
		output w2,
		output feat_load,
		output feat_data,
		output step_valid,
		output step_clear
	);

	modport lane
	(
		input w1,
		input w2,
		input feat_load,
		input feat_data,
		input step_valid,
		input step_clear
	);

endinterface

// ==== hw/mac_lane.sv ====
`timescale 1ns/1ps

module mac_lane
	import conv_pkg::*;
(
	input  logic clk,
	input  logic rst,

	// feature load
	input  logic load,
	input  logic [WORD_W-1:0] feat_in,

	// this lane's weights and step tags
	input  logic [WORD_W-1:0] w1_in,
	input  logic [WORD_W-1:0] w2_in,
	input  logic step_in,
	input  logic clear_in,

	output logic signed [ACC_W-1:0] prod1,
	output logic signed [ACC_W-1:0] prod2,
	output logic prod_valid,
	output logic prod_clear
);

	logic signed [WORD_W-1:0] feat;

	// feature register, a step in the same cycle still sees the old value
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			feat <= '0;
		end
		else if (load)
		begin
			feat <= feat_in;
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			prod1 <= '0;
			prod2 <= '0;
			prod_valid <= 1'b0;
			prod_clear <= 1'b0;
		end
		else
		begin
			prod_valid <= step_in;
			prod_clear <= step_in & clear_in;
			if (step_in)
			begin
				prod1 <= $signed(w1_in) * feat;
				prod2 <= $signed(w2_in) * feat;
			end
			else
			begin
				prod1 <= '0;
				prod2 <= '0;
			end
		end
	end

endmodule

// ==== hw/operand_dispatch.sv ====
`timescale 1ns/1ps

module operand_dispatch
	import conv_pkg::*;
#(
	parameter int MEM_DEPTH = 1024,
	parameter int ADDR_W = 10
)
(
	input  logic clk,
	input  logic rst,

	// weight writes
	input  logic weight_we,
	input  logic [ADDR_W-1:0] weight_addr,
	input  logic [WORD_W-1:0] weight_data,

	// feature writes
	input  logic feat_we,
	input  logic [$clog2(LANES)-1:0] feat_addr,
	input  logic [WORD_W-1:0] feat_data,

	// compute step
	input  logic step,
	input  layer_mode_t step_mode,
	input  logic [15:0] step_addr,
	input  logic acc_clear,

	lane_bus.dispatch bus
);

	layer_mode_t rd_mode;

	// no step means zero weights on the bus
	assign rd_mode = step ? step_mode : MODE_IDLE;

	weight_mem #(
		.MEM_DEPTH(MEM_DEPTH),
		.ADDR_W(ADDR_W)
	) u_weight_mem (
		.clk(clk),
		.rst(rst),
		.we(weight_we),
		.waddr(weight_addr),
		.wdata(weight_data),
		.rd_addr(step_addr),
		.rd_mode(rd_mode),
		.group1(bus.w1),
		.group2(bus.w2)
	);

	//////////////////////////////
	// feature load decode
	//////////////////////////////

	assign bus.feat_load = feat_we ? (LANES'(1) << feat_addr) : '0;
	assign bus.feat_data = feat_data;

	// step tags go straight through, lanes register them
	assign bus.step_valid = step;
	assign bus.step_clear = acc_clear;

endmodule

// ==== hw/psum_collector.sv ====
`timescale 1ns/1ps

module psum_collector
	import conv_pkg::*;
(
	input  logic clk,
	input  logic rst,

	// products from all lanes, tags from lane 0
	input  logic [LANES-1:0][ACC_W-1:0] prod1_all,
	input  logic [LANES-1:0][ACC_W-1:0] prod2_all,
	input  logic prod_valid,
	input  logic prod_clear,

	output logic result_valid,
	output logic signed [ACC_W-1:0] result1,
	output logic signed [ACC_W-1:0] result2
);

	// index 0 is the first dot product, index 1 the second bank
	logic [1:0][LANES-1:0][ACC_W-1:0] prods;
	logic [1:0][ACC_W-1:0] sum;
	logic [1:0][ACC_W-1:0] acc;

	assign prods = {prod2_all, prod1_all};

	//////////////////////////////
	// adder tree
	//////////////////////////////

	// pairwise halving, each pass is one tree level
	always_comb
	begin
		logic [LANES-1:0][ACC_W-1:0] part;

		for (int k = 0; k < 2; k++)
		begin
			part = prods[k];
			for (int w = LANES / 2; w >= 1; w = w / 2)
			begin
				for (int j = 0; j < w; j++)
				begin
					part[j] = part[2 * j] + part[2 * j + 1];
				end
			end
			sum[k] = part[0];
		end
	end

	//////////////////////////////
	// accumulate
	//////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			acc <= '0;
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= prod_valid;
			if (prod_valid)
			begin
				for (int k = 0; k < 2; k++)
				begin
					// wraps modulo 2^ACC_W
					acc[k] <= prod_clear ? sum[k] : acc[k] + sum[k];
				end
			end
		end
	end

	assign result1 = acc[0];
	assign result2 = acc[1];

endmodule

// ==== hw/weight_mem.sv ====
`timescale 1ns/1ps

module weight_mem
	import conv_pkg::*;
#(
	parameter int MEM_DEPTH = 1024,
	parameter int ADDR_W = 10
)
(
	input  logic clk,
	input  logic rst,

	// write port
	input  logic we,
	input  logic [ADDR_W-1:0] waddr,
	input  logic [WORD_W-1:0] wdata,

	// group read
	input  logic [15:0] rd_addr,
	input  layer_mode_t rd_mode,
	output logic [LANES-1:0][WORD_W-1:0] group1,
	output logic [LANES-1:0][WORD_W-1:0] group2
);

	// second bank distance, reduced to the index width
	localparam logic [ADDR_W-1:0] BANK_STEP = ADDR_W'(BANK_OFFSET);

	logic [WORD_W-1:0] mem [MEM_DEPTH];

	logic [31:0] base_k3_full;
	logic [31:0] base_row_full;
	logic [ADDR_W-1:0] base_k3;
	logic [ADDR_W-1:0] base_row;

	//////////////////////////////
	// write
	//////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < MEM_DEPTH; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (we)
		begin
			mem[waddr] <= wdata;
		end
	end

	//////////////////////////////
	// read
	//////////////////////////////

	// kernel rows are 3 words apart, full rows 8
	assign base_k3_full = 32'(rd_addr) * 32'd3;
	assign base_row_full = 32'(rd_addr) << 3;

	// keeping only the low bits wraps every index modulo the depth
	assign base_k3 = base_k3_full[ADDR_W-1:0];
	assign base_row = base_row_full[ADDR_W-1:0];

	always_comb
	begin
		group1 = '0;
		group2 = '0;
		case (rd_mode)
			MODE_K3:
			begin
				// three taps, upper lanes stay zero
				for (int i = 0; i < 3; i++)
				begin
					group1[i] = mem[base_k3 + ADDR_W'(i)];
				end
			end
			MODE_ROW8, MODE_DUAL:
			begin
				for (int i = 0; i < LANES; i++)
				begin
					group1[i] = mem[base_row + ADDR_W'(i)];
				end
				if (rd_mode == MODE_DUAL)
				begin
					for (int i = 0; i < LANES; i++)
					begin
						group2[i] = mem[base_row + ADDR_W'(i) + BANK_STEP];
					end
				end
			end
			default:
			begin
				// idle, both groups stay zero
			end
		endcase
	end

endmodule

// ==== project.f ====
hw/conv_pkg.sv
hw/lane_bus.sv
hw/weight_mem.sv
hw/operand_dispatch.sv
hw/mac_lane.sv
hw/psum_collector.sv
hw/conv_engine_top.sv
tests/conv_engine_asserts.sv
tests/tb_conv_engine.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the conv engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_conv_engine \
	-f project.f \
	--Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

// ==== tests/conv_engine_asserts.sv ====
`timescale 1ns/1ps

module conv_engine_asserts
(
	input logic clk,
	input logic rst,
	input logic step,
	input logic result_valid
);

	// result_valid is a plain register, never x once out of reset
	a_valid_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(result_valid))
		else $error("result_valid is unknown");

	// lane register then collector register
	a_step_gives_result: assert property (@(posedge clk) disable iff (rst)
		$past(step, 2) |-> result_valid)
		else $error("step not followed by result_valid two cycles later");

	a_result_has_step: assert property (@(posedge clk) disable iff (rst)
		result_valid |-> $past(step, 2))
		else $error("result_valid without a step two cycles before");

endmodule

bind conv_engine_top conv_engine_asserts u_asserts
(
	.clk(clk),
	.rst(rst),
	.step(step),
	.result_valid(result_valid)
);

// ==== tests/tb_conv_engine.sv ====
`timescale 1ns/1ps

module tb_conv_engine
	import conv_pkg::*;
();

	localparam int MEM_DEPTH = 1024;
	localparam int ADDR_W = 10;
	localparam int RESET_CYCLES = 16;
	// the tests take about 1300 cycles, most of it the memory fill
	localparam int CYCLE_LIMIT = 4000;
	localparam int SEED = 32'h502b_f354;

	logic clk;
	logic rst;
	logic weight_we;
	logic [ADDR_W-1:0] weight_addr;
	logic [WORD_W-1:0] weight_data;
	logic feat_we;
	logic [2:0] feat_addr;
	logic [WORD_W-1:0] feat_data;
	logic step;
	layer_mode_t step_mode;
	logic [15:0] step_addr;
	logic acc_clear;
	logic result_valid;
	logic signed [ACC_W-1:0] result1;
	logic signed [ACC_W-1:0] result2;

	// reference model state
	logic [WORD_W-1:0] model_mem [MEM_DEPTH];
	logic signed [WORD_W-1:0] model_feat [LANES];
	logic [ACC_W-1:0] model_acc1;
	logic [ACC_W-1:0] model_acc2;
	logic [ACC_W-1:0] exp1_q [$];
	logic [ACC_W-1:0] exp2_q [$];
	logic [ACC_W-1:0] exp1;
	logic [ACC_W-1:0] exp2;
	int cycle_count = 0;

	conv_engine_top #(
		.MEM_DEPTH(MEM_DEPTH),
		.ADDR_W(ADDR_W)
	) DUT (
		.clk(clk),
		.rst(rst),
		.weight_we(weight_we),
		.weight_addr(weight_addr),
		.weight_data(weight_data),
		.feat_we(feat_we),
		.feat_addr(feat_addr),
		.feat_data(feat_data),
		.step(step),
		.step_mode(step_mode),
		.step_addr(step_addr),
		.acc_clear(acc_clear),
		.result_valid(result_valid),
		.result1(result1),
		.result2(result2)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////
	// reporting
	//////////////////////////////

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [ACC_W-1:0] got,
		input logic [ACC_W-1:0] want);
		assert (got === want)
		else fail_run($sformatf("Fail %s got %h expected %h", name, got, want));
	endtask

	//////////////////////////////
	// drivers and model
	//////////////////////////////

	task automatic write_weight(input int addr, input logic [WORD_W-1:0] data);
		@(posedge clk);
		weight_we <= 1'b1;
		weight_addr <= ADDR_W'(addr);
		weight_data <= data;
		feat_we <= 1'b0;
		step <= 1'b0;
		model_mem[addr % MEM_DEPTH] = data;
	endtask

	task automatic write_feature(input int lane, input logic [WORD_W-1:0] data);
		@(posedge clk);
		feat_we <= 1'b1;
		feat_addr <= 3'(lane);
		feat_data <= data;
		weight_we <= 1'b0;
		step <= 1'b0;
		model_feat[lane] = data;
	endtask

	task automatic issue_step(input layer_mode_t mode, input int addr, input bit clear);
		int s1;
		int s2;
		int base;
		@(posedge clk);
		step <= 1'b1;
		step_mode <= mode;
		step_addr <= 16'(addr);
		acc_clear <= clear;
		weight_we <= 1'b0;
		feat_we <= 1'b0;
		s1 = 0;
		s2 = 0;
		case (mode)
			MODE_K3:
			begin
				base = 3 * addr;
				for (int i = 0; i < 3; i++)
				begin
					s1 += int'($signed(model_mem[(base + i) % MEM_DEPTH])) * int'(model_feat[i]);
				end
			end
			MODE_ROW8, MODE_DUAL:
			begin
				base = 8 * addr;
				for (int i = 0; i < LANES; i++)
				begin
					s1 += int'($signed(model_mem[(base + i) % MEM_DEPTH])) * int'(model_feat[i]);
					if (mode == MODE_DUAL)
					begin
						s2 += int'($signed(model_mem[(base + i + BANK_OFFSET) % MEM_DEPTH]))
							* int'(model_feat[i]);
					end
				end
			end
			default:
			begin
			end
		endcase
		model_acc1 = clear ? ACC_W'(s1) : model_acc1 + ACC_W'(s1);
		model_acc2 = clear ? ACC_W'(s2) : model_acc2 + ACC_W'(s2);
		exp1_q.push_back(model_acc1);
		exp2_q.push_back(model_acc2);
	endtask

	task automatic release_inputs();
		@(posedge clk);
		weight_we <= 1'b0;
		feat_we <= 1'b0;
		step <= 1'b0;
		acc_clear <= 1'b0;
	endtask

	task automatic wait_results();
		release_inputs();
		while (exp1_q.size() != 0)
		begin
			@(posedge clk);
		end
	endtask

	// outputs are compared mid-cycle, away from the edge
	always @(negedge clk)
	begin
		if (!rst && result_valid)
		begin
			if (exp1_q.size() == 0)
			begin
				fail_run("result_valid pulsed with no step outstanding");
			end
			else
			begin
				exp1 = exp1_q.pop_front();
				exp2 = exp2_q.pop_front();
				check_value("result1", result1, exp1);
				check_value("result2", result2, exp2);
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			fail_run("run did not finish within the cycle limit");
		end
	end

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic test_reset_state();
		repeat (4)
		begin
			@(negedge clk);
			assert (result_valid === 1'b0)
			else fail_run("result_valid high while idle after reset");
			check_value("result1", result1, '0);
			check_value("result2", result2, '0);
		end
		// rows that address 5 selects in the other modes, idle must ignore them
		for (int i = 0; i < LANES; i++)
		begin
			write_feature(i, 16'(i + 1));
			write_weight(15 + i, 16'(i + 2));
			write_weight(40 + i, 16'(i + 2));
		end
		issue_step(MODE_IDLE, 5, 1'b1);
		wait_results();
		check_value("result1", result1, '0);
		check_value("result2", result2, '0);
	endtask

	task automatic test_k3();
		// row 7 starts at word 21, word 24 must stay unused
		write_weight(21, 16'h0003);
		write_weight(22, 16'hfffe);
		write_weight(23, 16'h0005);
		write_weight(24, 16'h7777);
		for (int i = 0; i < LANES; i++)
		begin
			write_feature(i, 16'(10 * i + 4));
		end
		issue_step(MODE_K3, 7, 1'b1);
		wait_results();
		// 3*4 - 2*14 + 5*24
		check_value("result1", result1, 32'd104);
		check_value("result2", result2, '0);
	endtask

	task automatic test_row8_accumulate();
		for (int i = 0; i < LANES; i++)
		begin
			write_feature(i, 16'($urandom));
			write_weight(16 + i, 16'($urandom));
			write_weight(40 + i, 16'($urandom));
			write_weight(72 + i, 16'($urandom));
		end
		issue_step(MODE_ROW8, 2, 1'b1);
		issue_step(MODE_ROW8, 5, 1'b0);
		issue_step(MODE_ROW8, 9, 1'b0);
		issue_step(MODE_ROW8, 5, 1'b1);
		wait_results();
	endtask

	task automatic test_dual();
		for (int i = 0; i < LANES; i++)
		begin
			write_weight(24 + i, 16'(-(i + 1)));
			write_weight(24 + BANK_OFFSET + i, 16'(3 * i - 10));
			write_feature(i, 16'(-(100 * i) - 7));
		end
		issue_step(MODE_DUAL, 3, 1'b1);
		wait_results();
	endtask

	task automatic test_random_batches();
		int addr;
		// fill the whole memory, kernel rows and second banks land all over it
		for (int i = 0; i < MEM_DEPTH; i++)
		begin
			write_weight(i, 16'($urandom));
		end
		for (int b = 0; b < 4; b++)
		begin
			for (int i = 0; i < LANES; i++)
			begin
				write_feature(i, 16'($urandom));
			end
			for (int s = 0; s < 8; s++)
			begin
				addr = $urandom_range(0, 3) + 124 * $urandom_range(0, 1)
					+ 128 * $urandom_range(0, 511);
				issue_step(layer_mode_t'($urandom_range(0, 3)), addr,
					(s == 0) || ($urandom_range(0, 3) == 0));
			end
			release_inputs();
		end
		wait_results();
	endtask

	initial
	begin
		rst = 1'b1;
		weight_we = 1'b0;
		weight_addr = '0;
		weight_data = '0;
		feat_we = 1'b0;
		feat_addr = '0;
		feat_data = '0;
		step = 1'b0;
		step_mode = MODE_IDLE;
		step_addr = '0;
		acc_clear = 1'b0;
		model_acc1 = '0;
		model_acc2 = '0;
		for (int i = 0; i < MEM_DEPTH; i++)
		begin
			model_mem[i] = '0;
		end
		for (int i = 0; i < LANES; i++)
		begin
			model_feat[i] = '0;
		end
		void'($urandom(SEED));
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		test_reset_state();
		test_k3();
		test_row8_accumulate();
		test_dual();
		test_random_batches();

		if (exp1_q.size() == 0)
		begin
			$display("test passed");
			$finish;
		end
		else
		begin
			fail_run("results still outstanding at the end of the run");
		end
	end

endmodule
